// File: run.sh
#!/usr/bin/env bash
# Build the AFU testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

BUILD_DIR=build
LOG=sim.log

rm -rf "$BUILD_DIR" "$LOG"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_afu -Mdir "$BUILD_DIR" -f sources.f

# The simulator may stop early on an assertion, so its status is not used
"./$BUILD_DIR/Vtb_afu" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Testbench failed" "$LOG" || ! grep -q "Testbench passed" "$LOG"; then
   echo "Simulation failed, see $LOG"
   exit 1
fi
echo "Simulation passed"

// File: sources.f
verilog/qpi_pkg.sv
verilog/afu_csr.sv
verilog/status_writer.sv
verilog/tx1_fifo.sv
verilog/tx1_issue.sv
verilog/afu_top.sv
tests/afu_chk.sv
tests/tb_afu.sv

// File: tests/afu_chk.sv
`timescale 1ns/1ps

module afu_chk import qpi_pkg::*; (
   input logic      clk,
   input logic      resetb,

   // Producer handshake inside the AFU
   input logic      wr_request,
   input logic      wr_grant,

   // Tx1 write channel of the link
   input logic      tx1_almost_full,
   input logic      tx1_valid,
   input req_type_e tx1_type
);

   // Number of assertion failures seen so far
   int assert_errors = 0;

   // ============================================================
   // Request/grant between status writer and Tx1 buffer
   // ============================================================

   // A request that was not granted is still pending one cycle later
   request_held: assert property (
      @(posedge clk) disable iff (!resetb)
      (wr_request && !wr_grant) |=> wr_request
   ) else begin
      assert_errors++;
      $error("wr_request dropped before it was granted");
   end

   // ============================================================
   // Link rules
   // ============================================================

   // The link asked for a pause, so a new line must not start right after
   no_issue_when_full: assert property (
      @(posedge clk) disable iff (!resetb)
      $rose(tx1_valid) |-> !$past(tx1_almost_full)
   ) else begin
      assert_errors++;
      $error("tx1_valid rose one cycle after tx1_almost_full was high");
   end

   // Status traffic only ever uses full-line writes
   type_is_wrline: assert property (
      @(posedge clk) disable iff (!resetb)
      tx1_valid |-> (tx1_type == WrLine)
   ) else begin
      assert_errors++;
      $error("tx1_type is not WrLine while tx1_valid is high");
   end

endmodule

// Attach the checks to every AFU top level
bind afu_top afu_chk afu_chk_i (
   .clk             (clk),
   .resetb          (resetb),
   .wr_request      (wr_request),
   .wr_grant        (wr_grant),
   .tx1_almost_full (tx1_almost_full),
   .tx1_valid       (tx1_valid),
   .tx1_type        (tx1_type)
);

// File: tests/tb_afu.sv
`timescale 1ns/1ps

module tb_afu import qpi_pkg::*; ();

   // Cycle budgets of reset and the five tests, plus a margin on top
   localparam int RESET_CYCLES   = 10;
   localparam int LINE_WAIT      = 20;
   localparam int QUIET_WAIT     = 20;
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + 60 + 60 + 120 + 160 + 100 + 50;

   logic                  clk;
   logic                  resetb;
   logic                  csr_write;
   logic [CSR_ADDR_W-1:0] csr_addr;
   csr_word_u             csr_data;
   logic                  tx1_almost_full;
   logic                  tx1_valid;
   req_type_e             tx1_type;
   logic [CL_ADDR_W-1:0]  tx1_address;
   logic [CL_DATA_W-1:0]  tx1_data;

   logic [15:0]          lfsr_state = 16'd99;
   int                   cycle_count = 0;
   int                   error_count = 0;
   int                   check_count = 0;
   int                   test_count = 0;
   int                   failed_tests = 0;
   int                   lines_written = 0;
   logic [CL_ADDR_W-1:0] current_base = '0;

   // Every line seen on the link, oldest first
   logic [CL_ADDR_W-1:0] seen_addr [$];
   logic [CL_DATA_W-1:0] seen_data [$];
   req_type_e            seen_type [$];

   afu_top afu_top_i (
      .clk             (clk),
      .resetb          (resetb),
      .csr_write       (csr_write),
      .csr_addr        (csr_addr),
      .csr_data        (csr_data),
      .tx1_almost_full (tx1_almost_full),
      .tx1_valid       (tx1_valid),
      .tx1_type        (tx1_type),
      .tx1_address     (tx1_address),
      .tx1_data        (tx1_data)
   );

   always #5 clk = ~clk;

   // ============================================================
   // Timeout and link monitor
   // ============================================================

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Run stopped after %0d cycles before all tests finished", cycle_count);
         $display("Testbench failed");
         $finish;
      end
   end

   // Link outputs are registered, so the edge sees the values of the cycle before
   always @(posedge clk) begin
      if (resetb && tx1_valid) begin
         seen_addr.push_back(tx1_address);
         seen_data.push_back(tx1_data);
         seen_type.push_back(tx1_type);
      end
   end

   // ============================================================
   // Random numbers and expected values
   // ============================================================

   // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] state);
      return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
   endfunction

   // One LFSR step per bit of the word
   task automatic draw_random(output logic [31:0] value);
      value = '0;
      for (int i = 0; i < 32; i++) begin
         value = {value[30:0], lfsr_state[15]};
         lfsr_state = lfsr_step(lfsr_state);
      end
   endtask

   // Words 0 to 3 are magic with their index, word 4 counts earlier lines
   function automatic logic [CL_DATA_W-1:0] expected_line(input int prior_lines);
      logic [CL_DATA_W-1:0] line;
      line = '0;
      for (int w = 0; w < 4; w++) begin
         line[w*32 +: 32] = {STATUS_MAGIC, 16'(w)};
      end
      line[4*32 +: 32] = 32'(prior_lines);
      return line;
   endfunction

   // ============================================================
   // Compare tasks
   // ============================================================

   task automatic compare_addr(input string name, input logic [CL_ADDR_W-1:0] actual,
                               input logic [CL_ADDR_W-1:0] expected);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("** Error: %s is 0x%h, expected 0x%h", name, actual, expected);
      end
   endtask

   task automatic compare_data(input string name, input logic [CL_DATA_W-1:0] actual,
                               input logic [CL_DATA_W-1:0] expected);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("** Error: %s is 0x%h, expected 0x%h", name, actual, expected);
      end
   endtask

   task automatic compare_type(input string name, input req_type_e actual,
                               input req_type_e expected);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("** Error: %s is 0x%h, expected 0x%h", name, actual, expected);
      end
   endtask

   task automatic compare_flag(input string name, input logic actual, input logic expected);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("** Error: %s is 0x%h, expected 0x%h", name, actual, expected);
      end
   endtask

   // ============================================================
   // Stimulus and line checks
   // ============================================================

   // One-cycle CSR write strobe, driven between clock edges
   task automatic host_write(input logic [CSR_ADDR_W-1:0] addr, input csr_word_u word);
      @(negedge clk);
      csr_write = 1'b1;
      csr_addr  = addr;
      csr_data  = word;
      @(negedge clk);
      csr_write = 1'b0;
   endtask

   task automatic write_base(input logic [CL_ADDR_W-1:0] base);
      csr_word_u word;
      word          = '0;
      word.dsm_base = base;
      host_write(CSR_DSM_BASE, word);
      current_base = base;
   endtask

   task automatic write_ctrl(input logic [CSR_DATA_W-2:0] reserved, input logic clear);
      csr_word_u word;
      word.ctrl.reserved  = reserved;
      word.ctrl.dsm_clear = clear;
      host_write(CSR_AFU_CTRL, word);
   endtask

   // Latency varies with back-pressure, so wait for the line itself
   task automatic check_next_line(input logic [CL_ADDR_W-1:0] base);
      int waited;
      waited = 0;
      while (seen_addr.size() == 0 && waited < LINE_WAIT) begin
         @(negedge clk);
         waited++;
      end
      check_count++;
      if (seen_addr.size() == 0) begin
         error_count++;
         $display("No status line arrived on tx1 within %0d cycles", LINE_WAIT);
      end else begin
         compare_addr("tx1_address", seen_addr.pop_front(), dsm_offset2addr(10'd0, base));
         compare_data("tx1_data", seen_data.pop_front(), expected_line(lines_written));
         compare_type("tx1_type", seen_type.pop_front(), WrLine);
         lines_written++;
      end
   endtask

   // Nothing more may show up on the link for a while
   task automatic check_quiet(input int cycles);
      repeat (cycles) @(negedge clk);
      check_count++;
      if (seen_addr.size() != 0) begin
         error_count++;
         $display("%0d unexpected lines appeared on tx1", seen_addr.size());
         seen_addr.delete();
         seen_data.delete();
         seen_type.delete();
      end
   endtask

   task automatic report_test(input string name, input int errors_before);
      test_count++;
      if (error_count == errors_before) begin
         $display("test %s done, no errors", name);
      end else begin
         failed_tests++;
         $display("test %s done, %0d errors", name, error_count - errors_before);
      end
   endtask

   // ============================================================
   // Tests
   // ============================================================

   task automatic idle_after_reset();
      int errors_before;
      errors_before = error_count;
      check_quiet(50);
      report_test("idle_after_reset", errors_before);
   endtask

   task automatic single_base_write();
      int          errors_before;
      logic [31:0] base;
      errors_before = error_count;
      draw_random(base);
      write_base(base);
      check_next_line(current_base);
      check_quiet(QUIET_WAIT);
      report_test("single_base_write", errors_before);
   endtask

   task automatic rearm_after_clear();
      int          errors_before;
      logic [31:0] base;
      errors_before = error_count;
      // Clearing disarms the writer without sending anything
      write_ctrl('0, 1'b1);
      compare_flag("dsm_base_valid", afu_top_i.dsm_base_valid, 1'b0);
      check_quiet(5);
      draw_random(base);
      write_base(base);
      check_next_line(current_base);
      check_quiet(QUIET_WAIT);
      // A new base alone is enough to arm it again
      draw_random(base);
      write_base(base);
      check_next_line(current_base);
      check_quiet(QUIET_WAIT);
      report_test("rearm_after_clear", errors_before);
   endtask

   task automatic back_pressure();
      int                   errors_before;
      logic [31:0]          base;
      logic [CL_ADDR_W-1:0] bases [$];
      errors_before = error_count;
      @(negedge clk);
      tx1_almost_full = 1'b1;
      draw_random(base);
      write_base(base);
      // The line waits in the buffer while the link is almost full
      check_quiet(30);
      @(negedge clk);
      tx1_almost_full = 1'b0;
      check_next_line(current_base);
      check_quiet(QUIET_WAIT);
      // Three armings fill both entries and leave the third request waiting
      @(negedge clk);
      tx1_almost_full = 1'b1;
      repeat (3) begin
         draw_random(base);
         write_base(base);
         bases.push_back(base);
         repeat (2) @(negedge clk);
      end
      check_quiet(10);
      @(negedge clk);
      tx1_almost_full = 1'b0;
      while (bases.size() != 0) begin
         check_next_line(bases.pop_front());
      end
      check_quiet(QUIET_WAIT);
      report_test("back_pressure", errors_before);
   endtask

   task automatic ignored_writes();
      int          errors_before;
      logic [31:0] junk;
      csr_word_u   word;
      errors_before = error_count;
      draw_random(junk);
      word.dsm_base = junk;
      host_write(16'h1A08, word);
      draw_random(junk);
      write_ctrl(junk[30:0], 1'b0);
      check_quiet(QUIET_WAIT);
      compare_addr("dsm_base", afu_top_i.dsm_base, current_base);
      compare_flag("dsm_base_valid", afu_top_i.dsm_base_valid, 1'b1);
      draw_random(junk);
      write_base(junk);
      check_next_line(current_base);
      check_quiet(QUIET_WAIT);
      report_test("ignored_writes", errors_before);
   endtask

   initial begin
      clk             = 1'b0;
      resetb          = 1'b0;
      csr_write       = 1'b0;
      csr_addr        = '0;
      csr_data        = '0;
      tx1_almost_full = 1'b0;
      repeat (RESET_CYCLES) @(negedge clk);
      resetb = 1'b1;

      idle_after_reset();
      single_base_write();
      rearm_after_clear();
      back_pressure();
      ignored_writes();

      // Assertion failures in the bound checker count as errors too
      error_count += afu_top_i.afu_chk_i.assert_errors;

      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               test_count, failed_tests, check_count, error_count);
      if (error_count == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: verilog/afu_csr.sv
`timescale 1ns/1ps

module afu_csr import qpi_pkg::*; (
   input  logic                  clk,
   input  logic                  resetb,

   // Host CSR write port
   input  logic                  csr_write,
   input  logic [CSR_ADDR_W-1:0] csr_addr,
   input  csr_word_u             csr_data,

   // DSM base towards the status writer
   output logic [CL_ADDR_W-1:0]  dsm_base,
   output logic                  dsm_base_valid,
   output logic                  base_update
);

   // ==========================================================
   // Address decode
   // ==========================================================

   logic base_hit;
   logic ctrl_hit;
   logic clear_req;

   // Only the two known offsets do anything, all others are dropped
   assign base_hit = csr_write && (csr_addr == CSR_DSM_BASE);
   assign ctrl_hit = csr_write && (csr_addr == CSR_AFU_CTRL);

   // The control view of the word is only meaningful at the control offset
   assign clear_req = ctrl_hit && csr_data.ctrl.dsm_clear;

   // ==========================================================
   // Registers
   // ==========================================================

   // Valid flag and update pulse are control state and come out of reset low
   always_ff @(posedge clk) begin
      if (!resetb) begin
         dsm_base_valid <= 1'b0;
         base_update    <= 1'b0;
      end else begin
         // One pulse for every base write, even if the value repeats
         base_update <= base_hit;

         // A base write arms the writer and wins over a clear
         if (base_hit) begin
            dsm_base_valid <= 1'b1;
         end else if (clear_req) begin
            dsm_base_valid <= 1'b0;
         end
      end
   end

   // The base address is only looked at while the valid flag is high
   always_ff @(posedge clk) begin
      if (base_hit) begin
         // Same data word, read through the address view
         dsm_base <= csr_data.dsm_base;
      end
   end

   // Reserved control bits are ignored on purpose so that later
   // revisions can add fields without confusing this block

endmodule

// File: verilog/afu_top.sv
`timescale 1ns/1ps

module afu_top import qpi_pkg::*; (
   input  logic                  clk,
   input  logic                  resetb,

   // Host CSR write port
   input  logic                  csr_write,
   input  logic [CSR_ADDR_W-1:0] csr_addr,
   input  csr_word_u             csr_data,

   // Tx1 write channel of the link
   input  logic                  tx1_almost_full,
   output logic                  tx1_valid,
   output req_type_e             tx1_type,
   output logic [CL_ADDR_W-1:0]  tx1_address,
   output logic [CL_DATA_W-1:0]  tx1_data
);

   // CSR block to status writer
   logic [CL_ADDR_W-1:0] dsm_base;
   logic                 dsm_base_valid;
   logic                 base_update;

   // Status writer to Tx1 buffer
   logic                 wr_request;
   logic                 wr_grant;
   logic [CL_ADDR_W-1:0] wr_address;
   logic [CL_DATA_W-1:0] wr_data;

   // Tx1 buffer to issue stage
   logic                 q_valid;
   logic                 q_pop;
   logic [CL_ADDR_W-1:0] q_address;
   logic [CL_DATA_W-1:0] q_data;

   // ==========================================================
   // Host side
   // ==========================================================

   afu_csr afu_csr_i (
      .clk            (clk),
      .resetb         (resetb),
      .csr_write      (csr_write),
      .csr_addr       (csr_addr),
      .csr_data       (csr_data),
      .dsm_base       (dsm_base),
      .dsm_base_valid (dsm_base_valid),
      .base_update    (base_update)
   );

   // ==========================================================
   // Producer, buffer and link issue
   // ==========================================================

   status_writer status_writer_i (
      .clk            (clk),
      .resetb         (resetb),
      .dsm_base       (dsm_base),
      .dsm_base_valid (dsm_base_valid),
      .base_update    (base_update),
      .wr_request     (wr_request),
      .wr_grant       (wr_grant),
      .wr_address     (wr_address),
      .wr_data        (wr_data)
   );

   tx1_fifo tx1_fifo_i (
      .clk        (clk),
      .resetb     (resetb),
      .wr_request (wr_request),
      .wr_grant   (wr_grant),
      .wr_address (wr_address),
      .wr_data    (wr_data),
      .q_valid    (q_valid),
      .q_pop      (q_pop),
      .q_address  (q_address),
      .q_data     (q_data)
   );

   tx1_issue tx1_issue_i (
      .clk             (clk),
      .resetb          (resetb),
      .q_valid         (q_valid),
      .q_pop           (q_pop),
      .q_address       (q_address),
      .q_data          (q_data),
      .tx1_almost_full (tx1_almost_full),
      .tx1_valid       (tx1_valid),
      .tx1_type        (tx1_type),
      .tx1_address     (tx1_address),
      .tx1_data        (tx1_data)
   );

endmodule

// File: verilog/qpi_pkg.sv
package qpi_pkg;

   // ==========================================================
   // Link geometry
   // ==========================================================

   // Cache-line addresses count 64-byte lines, not bytes
   localparam int CL_ADDR_W = 32;

   // One cache line carries 512 bits of payload
   localparam int CL_DATA_W = 512;

   // Host CSR write port widths
   localparam int CSR_ADDR_W = 16;
   localparam int CSR_DATA_W = 32;

   // ==========================================================
   // CSR map
   // ==========================================================

   // Writing this offset loads the device status memory base
   localparam logic [CSR_ADDR_W-1:0] CSR_DSM_BASE = 16'h1A00;

   // Writing this offset with dsm_clear set disarms the status writer
   localparam logic [CSR_ADDR_W-1:0] CSR_AFU_CTRL = 16'h1A04;

   // ==========================================================
   // Tx1 buffer and status line layout
   // ==========================================================

   // Number of write transactions the Tx1 buffer can hold
   localparam int TX1_FIFO_DEPTH = 2;

   // Pointer and occupancy widths follow from the depth
   localparam int TX1_PTR_W = (TX1_FIFO_DEPTH > 1) ? $clog2(TX1_FIFO_DEPTH) : 1;
   localparam int TX1_CNT_W = $clog2(TX1_FIFO_DEPTH + 1);

   // The status line is cut into 32-bit words
   localparam int STATUS_WORD_W = 32;
   localparam int STATUS_WORDS = CL_DATA_W / STATUS_WORD_W;

   // The first words are fixed markers the host can check for
   localparam int STATUS_MAGIC_WORDS = 4;
   localparam logic [15:0] STATUS_MAGIC = 16'hACED;

   // This word carries the number of status lines written earlier
   localparam int STATUS_COUNT_WORD = 4;

   // ==========================================================
   // Types
   // ==========================================================

   // Write request types on the Tx1 channel
   typedef enum logic [3:0] {
      WrThru = 4'h1,
      WrLine = 4'h2
   } req_type_e;

   // Bit fields of the AFU control register
   typedef struct packed {
      logic [CSR_DATA_W-2:0] reserved;
      logic                  dsm_clear;
   } csr_ctrl_t;

   // A CSR data word means different things depending on the offset
   typedef union packed {
      logic [CL_ADDR_W-1:0] dsm_base;
      csr_ctrl_t            ctrl;
   } csr_word_u;

   // Turns a line offset inside the DSM into a full cache-line address
   function automatic logic [CL_ADDR_W-1:0] dsm_offset2addr(
      input logic [9:0]           offset,
      input logic [CL_ADDR_W-1:0] base
   );
      return base + CL_ADDR_W'(offset);
   endfunction

endpackage

// File: verilog/status_writer.sv
`timescale 1ns/1ps

module status_writer import qpi_pkg::*; (
   input  logic                 clk,
   input  logic                 resetb,

   // DSM base from the CSR block
   input  logic [CL_ADDR_W-1:0] dsm_base,
   input  logic                 dsm_base_valid,
   input  logic                 base_update,

   // Request/grant towards the Tx1 buffer
   output logic                 wr_request,
   input  logic                 wr_grant,
   output logic [CL_ADDR_W-1:0] wr_address,
   output logic [CL_DATA_W-1:0] wr_data
);

   typedef enum logic {IDLE, DONE} state_t;

   state_t                   state;
   state_t                   next_state;
   logic                     granted;
   logic [STATUS_WORD_W-1:0] write_count;

   // A transfer completes on any edge with request and grant both high
   assign granted = wr_request && wr_grant;

   // ==========================================================
   // FSM
   // ==========================================================

   always_ff @(posedge clk) begin
      if (!resetb) begin
         state <= IDLE;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         IDLE: begin
            // One line per arming, then wait
            if (granted) begin
               next_state = DONE;
            end
         end
         DONE: begin
            // A new base or a cleared base arms the writer again
            if (base_update || !dsm_base_valid) begin
               next_state = IDLE;
            end
         end
         default: next_state = IDLE;
      endcase
   end

   // Level request, held until the buffer grants it
   assign wr_request = (state == IDLE) && dsm_base_valid;

   // Counts lines handed over, so each line reports how many came before it
   always_ff @(posedge clk) begin
      if (!resetb) begin
         write_count <= '0;
      end else if (granted) begin
         write_count <= write_count + 1'b1;
      end
   end

   // ==========================================================
   // Status line and address
   // ==========================================================

   always_comb begin
      wr_data = '0;
      // Marker words hold the magic value with their own index below it
      for (int i = 0; i < STATUS_MAGIC_WORDS; i++) begin
         wr_data[i*STATUS_WORD_W +: STATUS_WORD_W] = {STATUS_MAGIC, 16'(i)};
      end
      wr_data[STATUS_COUNT_WORD*STATUS_WORD_W +: STATUS_WORD_W] = write_count;
   end

   // The status line sits at the very start of the DSM
   assign wr_address = dsm_offset2addr(10'd0, dsm_base);

endmodule

// File: verilog/tx1_fifo.sv
`timescale 1ns/1ps

module tx1_fifo import qpi_pkg::*; (
   input  logic                 clk,
   input  logic                 resetb,

   // Producer side, request/grant
   input  logic                 wr_request,
   output logic                 wr_grant,
   input  logic [CL_ADDR_W-1:0] wr_address,
   input  logic [CL_DATA_W-1:0] wr_data,

   // Consumer side, valid/pop
   output logic                 q_valid,
   input  logic                 q_pop,
   output logic [CL_ADDR_W-1:0] q_address,
   output logic [CL_DATA_W-1:0] q_data
);

   // Storage for granted write transactions
   logic [CL_ADDR_W-1:0] addr_mem [TX1_FIFO_DEPTH];
   logic [CL_DATA_W-1:0] data_mem [TX1_FIFO_DEPTH];

   logic [TX1_PTR_W-1:0] wr_ptr;
   logic [TX1_PTR_W-1:0] rd_ptr;
   logic [TX1_CNT_W-1:0] count;
   logic                 push;

   // ==========================================================
   // Handshakes
   // ==========================================================

   // Grant as long as there is a free slot, in the same cycle as the request
   assign wr_grant = (count != TX1_CNT_W'(TX1_FIFO_DEPTH));
   assign push     = wr_request && wr_grant;

   // The head entry is visible as soon as it has been written
   assign q_valid   = (count != '0);
   assign q_address = addr_mem[rd_ptr];
   assign q_data    = data_mem[rd_ptr];

   // ==========================================================
   // Pointers and occupancy
   // ==========================================================

   always_ff @(posedge clk) begin
      if (!resetb) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // Pointers wrap explicitly so the depth need not be a power of two
         if (push) begin
            wr_ptr <= (wr_ptr == TX1_PTR_W'(TX1_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (q_pop) begin
            rd_ptr <= (rd_ptr == TX1_PTR_W'(TX1_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // Push and pop in the same cycle leave the count alone
         case ({push, q_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Entries are written on push only
   always_ff @(posedge clk) begin
      if (push) begin
         addr_mem[wr_ptr] <= wr_address;
         data_mem[wr_ptr] <= wr_data;
      end
   end

endmodule

// File: verilog/tx1_issue.sv
`timescale 1ns/1ps

module tx1_issue import qpi_pkg::*; (
   input  logic                 clk,
   input  logic                 resetb,

   // Tx1 buffer head
   input  logic                 q_valid,
   output logic                 q_pop,
   input  logic [CL_ADDR_W-1:0] q_address,
   input  logic [CL_DATA_W-1:0] q_data,

   // Tx1 write channel of the link
   input  logic                 tx1_almost_full,
   output logic                 tx1_valid,
   output req_type_e            tx1_type,
   output logic [CL_ADDR_W-1:0] tx1_address,
   output logic [CL_DATA_W-1:0] tx1_data
);

   // ==========================================================
   // Pop decision
   // ==========================================================

   // Nothing leaves the buffer while the link signals almost full.
   // The pop is gated by q_valid, so an empty buffer is never popped
   assign q_pop = q_valid && !tx1_almost_full;

   // ==========================================================
   // Link outputs
   // ==========================================================

   // Valid is a one-cycle pulse per popped line
   always_ff @(posedge clk) begin
      if (!resetb) begin
         tx1_valid <= 1'b0;
      end else begin
         tx1_valid <= q_pop;
      end
   end

   // Header and payload are only sampled by the link while valid is high
   always_ff @(posedge clk) begin
      if (q_pop) begin
         // All status traffic is a full-line write
         tx1_type    <= WrLine;
         tx1_address <= q_address;
         tx1_data    <= q_data;
      end
   end

endmodule
